// File: common/vrf_settings.svh
`ifndef VRF_SETTINGS_SVH
`define VRF_SETTINGS_SVH

//////////////////////////////
// Memory geometry
//////////////////////////////

// Data word width, one memory word per access
`define VRF_WORD_W 32

// Word address width of the data memory
`define VRF_ADDR_W 10

//////////////////////////////
// Operation limits
//////////////////////////////

// Width of the vector length field
`define VRF_VL_W 16

// Operand pairs held between memory and the execution unit
`define VRF_QUEUE_DEPTH 2

`endif

// File: common/vrf_pkg.sv
`default_nettype none

`include "vrf_settings.svh"

package vrf_pkg;

  //////////////////////////////
  // Element width
  //////////////////////////////

  // Value is the shift from elements to bytes
  typedef enum logic [1:0] {
    SEW_8  = 2'd0,
    SEW_16 = 2'd1,
    SEW_32 = 2'd2
  } sew_e;

  //////////////////////////////
  // Vector sizing
  //////////////////////////////

  // Words covered by one vector register operand
  typedef logic [`VRF_VL_W-1:0] word_cnt_t;

  //////////////////////////////
  // Memory request
  //////////////////////////////

  // One access on the shared data memory port
  typedef struct packed {
    // High for a write
    logic                   we;
    // Word address
    logic [`VRF_ADDR_W-1:0] addr;
    // Byte lanes, all set for reads
    logic [3:0]             be;
    // Ignored for reads
    logic [`VRF_WORD_W-1:0] wdata;
  } mem_req_t;

endpackage

`default_nettype wire

// File: src/vrf_op_ctrl.sv
`include "vrf_settings.svh"

`timescale 1ns/100ps
`default_nettype none

module vrf_op_ctrl import vrf_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Operation port
  input  logic                   op_valid_i,
  output logic                   op_ready_o,
  input  logic                   op_binary_i,
  input  logic [`VRF_VL_W-1:0]   vl_i,
  input  sew_e                   sew_i,
  input  logic [`VRF_ADDR_W-1:0] vs1_addr_i,
  input  logic [`VRF_ADDR_W-1:0] vs2_addr_i,
  input  logic [`VRF_ADDR_W-1:0] vd_addr_i,
  output logic                   done_o,

  // Reader and writer control
  input  logic                   wr_last_i,
  output logic                   start_o,
  output logic                   binary_o,
  output word_cnt_t              word_cnt_o,
  output logic [3:0]             tail_be_o,
  output logic [`VRF_ADDR_W-1:0] vs1_base_o,
  output logic [`VRF_ADDR_W-1:0] vs2_base_o,
  output logic [`VRF_ADDR_W-1:0] vd_base_o
);

  logic                 busy_q;
  logic                 accept;
  logic                 zero_vl;
  logic [`VRF_VL_W+1:0] byte_cnt;
  word_cnt_t            word_cnt;
  logic [3:0]           tail_be;
  logic                 start_q;
  logic                 done_q;

  assign op_ready_o = !busy_q;
  assign accept     = op_valid_i && op_ready_o;
  assign zero_vl    = (vl_i == '0);

  //////////////////////////////
  // Size of the vector
  //////////////////////////////

  assign byte_cnt = {2'b00, vl_i} << sew_i;

  // Round up to whole words
  assign word_cnt = byte_cnt[`VRF_VL_W+1:2] + word_cnt_t'(|byte_cnt[1:0]);

  // Byte lanes of the last word
  always_comb begin
    case (byte_cnt[1:0])
      2'b01:   tail_be = 4'b0001;
      2'b10:   tail_be = 4'b0011;
      2'b11:   tail_be = 4'b0111;
      default: tail_be = 4'b1111;
    endcase
  end

  //////////////////////////////
  // Idle / busy
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      start_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      start_q <= accept && !zero_vl;
      // Empty vector finishes right away
      done_q  <= (accept && zero_vl) || wr_last_i;
      if (accept) begin
        busy_q <= !zero_vl;
      end else if (wr_last_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Operation fields stay put until the next acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      binary_o   <= op_binary_i;
      word_cnt_o <= word_cnt;
      tail_be_o  <= tail_be;
      vs1_base_o <= vs1_addr_i;
      vs2_base_o <= vs2_addr_i;
      vd_base_o  <= vd_addr_i;
    end
  end

  assign start_o = start_q;
  assign done_o  = done_q;

  // Writer only finishes an operation that was started here
  wr_last_busy_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni) wr_last_i |-> busy_q
  );

endmodule

`default_nettype wire

// File: src/vrf_operand_fetch.sv
`include "vrf_settings.svh"

`timescale 1ns/100ps
`default_nettype none

module vrf_operand_fetch import vrf_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // From the operation control
  input  logic                   start_i,
  input  logic                   binary_i,
  input  word_cnt_t              word_cnt_i,
  input  logic [`VRF_ADDR_W-1:0] vs1_base_i,
  input  logic [`VRF_ADDR_W-1:0] vs2_base_i,

  // Read side of the arbiter
  output logic                   rd_req_o,
  output mem_req_t               rd_payload_o,
  input  logic                   rd_gnt_i,
  input  logic                   rd_rvalid_i,
  input  logic [`VRF_WORD_W-1:0] rd_rdata_i,

  // Operand port
  output logic                   opnd_valid_o,
  output logic [`VRF_WORD_W-1:0] opnd_a_o,
  output logic [`VRF_WORD_W-1:0] opnd_b_o,
  input  logic                   opnd_ready_i
);

  localparam int unsigned queue_depth = `VRF_QUEUE_DEPTH;
  localparam int unsigned ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
  localparam int unsigned cnt_w = $clog2(queue_depth + 1) + 1;

  logic                   active_q;
  logic                   phase_q;
  logic                   ret_phase_q;
  word_cnt_t              idx_q;
  word_cnt_t              idx_nxt;
  logic                   first_rd;
  logic                   space_ok;
  logic [cnt_w-1:0]       pend_q;
  logic [cnt_w-1:0]       count_q;
  logic [`VRF_WORD_W-1:0] a_q;
  logic [`VRF_WORD_W-1:0] a_mem [queue_depth];
  logic [`VRF_WORD_W-1:0] b_mem [queue_depth];
  logic [ptr_w-1:0]       wr_ptr_q;
  logic [ptr_w-1:0]       rd_ptr_q;
  logic                   push;
  logic                   pop;

  //////////////////////////////
  // Read issue
  //////////////////////////////

  // Phase 0 reads vs1, phase 1 reads vs2
  assign first_rd = !(binary_i && phase_q);
  assign idx_nxt  = idx_q + 1'b1;
  // A new pair needs a queue slot reserved up front
  assign space_ok = (count_q + pend_q) < cnt_w'(queue_depth);
  assign rd_req_o = active_q && (!first_rd || space_ok);

  always_comb begin
    rd_payload_o.we    = 1'b0;
    rd_payload_o.addr  = (phase_q ? vs2_base_i : vs1_base_i) + idx_q[`VRF_ADDR_W-1:0];
    rd_payload_o.be    = 4'b1111;
    rd_payload_o.wdata = '0;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q    <= 1'b0;
      phase_q     <= 1'b0;
      ret_phase_q <= 1'b0;
      idx_q       <= '0;
    end else begin
      if (start_i) begin
        active_q    <= 1'b1;
        phase_q     <= !binary_i;
        ret_phase_q <= !binary_i;
        idx_q       <= '0;
      end else begin
        if (rd_gnt_i) begin
          if (!phase_q) begin
            phase_q <= 1'b1;
          end else begin
            phase_q <= !binary_i;
            idx_q   <= idx_nxt;
            if (idx_nxt == word_cnt_i) active_q <= 1'b0;
          end
        end
        // Data returns in issue order
        if (rd_rvalid_i) ret_phase_q <= ret_phase_q ? !binary_i : 1'b1;
      end
    end
  end

  //////////////////////////////
  // Operand queue
  //////////////////////////////

  assign push = rd_rvalid_i && ret_phase_q;
  assign pop  = opnd_valid_o && opnd_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q   <= '0;
      count_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      // Pairs with a read granted but not yet queued
      case ({rd_gnt_i && first_rd, push})
        2'b10:   pend_q <= pend_q + 1'b1;
        2'b01:   pend_q <= pend_q - 1'b1;
        default: pend_q <= pend_q;
      endcase
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      if (push) wr_ptr_q <= (wr_ptr_q == ptr_w'(queue_depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= (rd_ptr_q == ptr_w'(queue_depth - 1)) ? '0 : rd_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_rvalid_i && !ret_phase_q) a_q <= rd_rdata_i;
    if (push) begin
      a_mem[wr_ptr_q] <= a_q;
      b_mem[wr_ptr_q] <= rd_rdata_i;
    end
  end

  assign opnd_valid_o = (count_q != '0);
  assign opnd_a_o     = a_mem[rd_ptr_q];
  assign opnd_b_o     = b_mem[rd_ptr_q];

  // Stalled operands must not change under the execution unit
  opnd_stable_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    opnd_valid_o && !opnd_ready_i |=> opnd_valid_o && $stable(opnd_a_o) && $stable(opnd_b_o)
  );

endmodule

`default_nettype wire

// File: src/vrf_result_write.sv
`include "vrf_settings.svh"

`timescale 1ns/100ps
`default_nettype none

module vrf_result_write import vrf_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // From the operation control
  input  logic                   start_i,
  input  word_cnt_t              word_cnt_i,
  input  logic [3:0]             tail_be_i,
  input  logic [`VRF_ADDR_W-1:0] vd_base_i,
  output logic                   wr_last_o,

  // Result port
  input  logic                   res_valid_i,
  input  logic [`VRF_WORD_W-1:0] res_data_i,
  output logic                   res_ready_o,

  // Write side of the arbiter
  output logic                   wr_req_o,
  output mem_req_t               wr_payload_o,
  input  logic                   wr_gnt_i
);

  word_cnt_t              rem_q;
  word_cnt_t              idx_q;
  logic                   pend_q;
  logic [`VRF_ADDR_W-1:0] addr_q;
  logic [3:0]             be_q;
  logic [`VRF_WORD_W-1:0] wdata_q;
  logic                   accept;

  // One write in flight at a time
  assign res_ready_o = !pend_q && (rem_q != '0);
  assign accept      = res_valid_i && res_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rem_q  <= '0;
      idx_q  <= '0;
      pend_q <= 1'b0;
    end else begin
      if (start_i) begin
        rem_q <= word_cnt_i;
        idx_q <= '0;
      end else if (accept) begin
        rem_q <= rem_q - 1'b1;
        idx_q <= idx_q + 1'b1;
      end
      if (accept) begin
        pend_q <= 1'b1;
      end else if (wr_gnt_i) begin
        pend_q <= 1'b0;
      end
    end
  end

  // Write request fields
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= vd_base_i + idx_q[`VRF_ADDR_W-1:0];
      // Partial lanes only on the final word
      be_q    <= (rem_q == word_cnt_t'(1)) ? tail_be_i : 4'b1111;
      wdata_q <= res_data_i;
    end
  end

  assign wr_req_o = pend_q;

  always_comb begin
    wr_payload_o.we    = 1'b1;
    wr_payload_o.addr  = addr_q;
    wr_payload_o.be    = be_q;
    wr_payload_o.wdata = wdata_q;
  end

  // Count already at zero means this is the vector's last word
  assign wr_last_o = wr_gnt_i && (rem_q == '0);

  // Nothing may be written past the end of vd
  wr_overrun_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    wr_gnt_i |-> (idx_q != '0) && (idx_q <= word_cnt_i)
  );

endmodule

`default_nettype wire

// File: src/vrf_mem_arbiter.sv
`include "vrf_settings.svh"

`timescale 1ns/100ps
`default_nettype none

module vrf_mem_arbiter import vrf_pkg::*; #(
  parameter type req_t = mem_req_t
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Port a, high priority
  input  logic                   a_req_i,
  input  req_t                   a_payload_i,
  output logic                   a_gnt_o,

  // Port b, reads come back here
  input  logic                   b_req_i,
  input  req_t                   b_payload_i,
  output logic                   b_gnt_o,
  output logic                   b_rvalid_o,
  output logic [`VRF_WORD_W-1:0] b_rdata_o,

  // Data memory
  output logic                   mem_req_o,
  output logic                   mem_we_o,
  output logic [`VRF_ADDR_W-1:0] mem_addr_o,
  output logic [3:0]             mem_be_o,
  output logic [`VRF_WORD_W-1:0] mem_wdata_o,
  input  logic                   mem_gnt_i,
  input  logic                   mem_rvalid_i,
  input  logic [`VRF_WORD_W-1:0] mem_rdata_i
);

  req_t sel_payload;
  logic rd_inflight_q;

  // Fixed priority for port a
  assign sel_payload = a_req_i ? a_payload_i : b_payload_i;
  assign mem_req_o   = a_req_i || b_req_i;
  assign mem_we_o    = sel_payload.we;
  assign mem_addr_o  = sel_payload.addr;
  assign mem_be_o    = sel_payload.be;
  assign mem_wdata_o = sel_payload.wdata;

  assign a_gnt_o = a_req_i && mem_gnt_i;
  assign b_gnt_o = b_req_i && !a_req_i && mem_gnt_i;

  // Read data follows its grant by one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_inflight_q <= 1'b0;
    end else begin
      rd_inflight_q <= mem_req_o && mem_gnt_i && !mem_we_o;
    end
  end

  assign b_rvalid_o = mem_rvalid_i && rd_inflight_q;
  assign b_rdata_o  = mem_rdata_i;

  rvalid_expected_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni) mem_rvalid_i |-> rd_inflight_q
  );

endmodule

`default_nettype wire

// File: src/vrf_seq_top.sv
`include "vrf_settings.svh"

`timescale 1ns/100ps
`default_nettype none

module vrf_seq_top import vrf_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Operation port
  input  logic                   op_valid_i,
  output logic                   op_ready_o,
  input  logic                   op_binary_i,
  input  logic [`VRF_VL_W-1:0]   vl_i,
  input  sew_e                   sew_i,
  input  logic [`VRF_ADDR_W-1:0] vs1_addr_i,
  input  logic [`VRF_ADDR_W-1:0] vs2_addr_i,
  input  logic [`VRF_ADDR_W-1:0] vd_addr_i,
  output logic                   done_o,

  // Operand port
  output logic                   opnd_valid_o,
  output logic [`VRF_WORD_W-1:0] opnd_a_o,
  output logic [`VRF_WORD_W-1:0] opnd_b_o,
  input  logic                   opnd_ready_i,

  // Result port
  input  logic                   res_valid_i,
  input  logic [`VRF_WORD_W-1:0] res_data_i,
  output logic                   res_ready_o,

  // Data memory
  output logic                   mem_req_o,
  output logic                   mem_we_o,
  output logic [`VRF_ADDR_W-1:0] mem_addr_o,
  output logic [3:0]             mem_be_o,
  output logic [`VRF_WORD_W-1:0] mem_wdata_o,
  input  logic                   mem_gnt_i,
  input  logic                   mem_rvalid_i,
  input  logic [`VRF_WORD_W-1:0] mem_rdata_i
);

  logic                   start;
  logic                   binary;
  word_cnt_t              word_cnt;
  logic [3:0]             tail_be;
  logic [`VRF_ADDR_W-1:0] vs1_base;
  logic [`VRF_ADDR_W-1:0] vs2_base;
  logic [`VRF_ADDR_W-1:0] vd_base;
  logic                   wr_last;
  logic                   rd_req;
  mem_req_t               rd_payload;
  logic                   rd_gnt;
  logic                   rd_rvalid;
  logic [`VRF_WORD_W-1:0] rd_rdata;
  logic                   wr_req;
  mem_req_t               wr_payload;
  logic                   wr_gnt;

  vrf_op_ctrl u_op_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .op_valid_i  (op_valid_i),
    .op_ready_o  (op_ready_o),
    .op_binary_i (op_binary_i),
    .vl_i        (vl_i),
    .sew_i       (sew_i),
    .vs1_addr_i  (vs1_addr_i),
    .vs2_addr_i  (vs2_addr_i),
    .vd_addr_i   (vd_addr_i),
    .done_o      (done_o),
    .wr_last_i   (wr_last),
    .start_o     (start),
    .binary_o    (binary),
    .word_cnt_o  (word_cnt),
    .tail_be_o   (tail_be),
    .vs1_base_o  (vs1_base),
    .vs2_base_o  (vs2_base),
    .vd_base_o   (vd_base)
  );

  vrf_operand_fetch u_operand_fetch (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start),
    .binary_i     (binary),
    .word_cnt_i   (word_cnt),
    .vs1_base_i   (vs1_base),
    .vs2_base_i   (vs2_base),
    .rd_req_o     (rd_req),
    .rd_payload_o (rd_payload),
    .rd_gnt_i     (rd_gnt),
    .rd_rvalid_i  (rd_rvalid),
    .rd_rdata_i   (rd_rdata),
    .opnd_valid_o (opnd_valid_o),
    .opnd_a_o     (opnd_a_o),
    .opnd_b_o     (opnd_b_o),
    .opnd_ready_i (opnd_ready_i)
  );

  vrf_result_write u_result_write (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start),
    .word_cnt_i   (word_cnt),
    .tail_be_i    (tail_be),
    .vd_base_i    (vd_base),
    .wr_last_o    (wr_last),
    .res_valid_i  (res_valid_i),
    .res_data_i   (res_data_i),
    .res_ready_o  (res_ready_o),
    .wr_req_o     (wr_req),
    .wr_payload_o (wr_payload),
    .wr_gnt_i     (wr_gnt)
  );

  // Writer on port a so results drain ahead of new reads
  vrf_mem_arbiter #(
    .req_t (mem_req_t)
  ) u_mem_arbiter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .a_req_i      (wr_req),
    .a_payload_i  (wr_payload),
    .a_gnt_o      (wr_gnt),
    .b_req_i      (rd_req),
    .b_payload_i  (rd_payload),
    .b_gnt_o      (rd_gnt),
    .b_rvalid_o   (rd_rvalid),
    .b_rdata_o    (rd_rdata),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_be_o     (mem_be_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i)
  );

endmodule

`default_nettype wire

// File: sim/tb_vrf_mem.sv
`include "vrf_settings.svh"

`timescale 1ns/100ps
`default_nettype none

module vrf_mem_model (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   mem_req_i,
  input  logic                   mem_we_i,
  input  logic [`VRF_ADDR_W-1:0] mem_addr_i,
  input  logic [3:0]             mem_be_i,
  input  logic [`VRF_WORD_W-1:0] mem_wdata_i,
  output logic                   mem_gnt_o,
  output logic                   mem_rvalid_o,
  output logic [`VRF_WORD_W-1:0] mem_rdata_o
);

  // Word storage, preloaded by the testbench
  logic [`VRF_WORD_W-1:0] mem [1 << `VRF_ADDR_W];

  // Access granted on the coming rising edge
  logic                   rd_pend;
  logic [`VRF_WORD_W-1:0] rd_word;
  logic                   wr_pend;
  logic [`VRF_ADDR_W-1:0] wr_addr;
  logic [3:0]             wr_be;
  logic [`VRF_WORD_W-1:0] wr_data;

  initial begin
    int b;
    mem_gnt_o    = 1'b0;
    mem_rvalid_o = 1'b0;
    mem_rdata_o  = '0;
    rd_pend      = 1'b0;
    rd_word      = '0;
    wr_pend      = 1'b0;
    wr_addr      = '0;
    wr_be        = '0;
    wr_data      = '0;
    forever begin
      @(negedge clk_i);
      if (wr_pend) begin
        for (b = 0; b < 4; b++) begin
          if (wr_be[b]) mem[wr_addr][8*b +: 8] = wr_data[8*b +: 8];
        end
      end
      // Read data lands one cycle after its grant
      mem_rvalid_o = rd_pend;
      mem_rdata_o  = rd_pend ? rd_word : '0;
      // Roughly one cycle in four without grant
      mem_gnt_o    = rst_ni && ($urandom_range(3) != 0);
      #1;
      rd_pend = 1'b0;
      wr_pend = 1'b0;
      if (mem_req_i && mem_gnt_o) begin
        if (mem_we_i) begin
          wr_pend = 1'b1;
          wr_addr = mem_addr_i;
          wr_be   = mem_be_i;
          wr_data = mem_wdata_i;
        end else begin
          rd_pend = 1'b1;
          rd_word = mem[mem_addr_i];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_vrf_seq.sv
`include "vrf_settings.svh"

`timescale 1ns/100ps
`default_nettype none

module tb_vrf_seq import vrf_pkg::*; ();

  localparam int mem_words = 1 << `VRF_ADDR_W;

  logic                   clk_i = 1'b0;
  logic                   rst_ni;
  logic                   op_valid_i;
  logic                   op_ready_o;
  logic                   op_binary_i;
  logic [`VRF_VL_W-1:0]   vl_i;
  sew_e                   sew_i;
  logic [`VRF_ADDR_W-1:0] vs1_addr_i;
  logic [`VRF_ADDR_W-1:0] vs2_addr_i;
  logic [`VRF_ADDR_W-1:0] vd_addr_i;
  logic                   done_o;
  logic                   opnd_valid_o;
  logic [`VRF_WORD_W-1:0] opnd_a_o;
  logic [`VRF_WORD_W-1:0] opnd_b_o;
  logic                   opnd_ready_i;
  logic                   res_valid_i;
  logic [`VRF_WORD_W-1:0] res_data_i;
  logic                   res_ready_o;
  logic                   mem_req_o;
  logic                   mem_we_o;
  logic [`VRF_ADDR_W-1:0] mem_addr_o;
  logic [3:0]             mem_be_o;
  logic [`VRF_WORD_W-1:0] mem_wdata_o;
  logic                   mem_gnt_i;
  logic                   mem_rvalid_i;
  logic [`VRF_WORD_W-1:0] mem_rdata_i;

  logic [`VRF_WORD_W-1:0] snap [mem_words];
  logic [`VRF_WORD_W-1:0] exp_mem [mem_words];
  logic                   cur_binary = 1'b0;
  bit                     in_op = 1'b0;
  bit                     timed_out = 1'b0;
  int                     err_cnt = 0;
  int                     check_cnt = 0;
  int                     done_cnt = 0;
  int                     req_cnt = 0;

  always #5 clk_i = ~clk_i;

  vrf_seq_top dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .op_valid_i   (op_valid_i),
    .op_ready_o   (op_ready_o),
    .op_binary_i  (op_binary_i),
    .vl_i         (vl_i),
    .sew_i        (sew_i),
    .vs1_addr_i   (vs1_addr_i),
    .vs2_addr_i   (vs2_addr_i),
    .vd_addr_i    (vd_addr_i),
    .done_o       (done_o),
    .opnd_valid_o (opnd_valid_o),
    .opnd_a_o     (opnd_a_o),
    .opnd_b_o     (opnd_b_o),
    .opnd_ready_i (opnd_ready_i),
    .res_valid_i  (res_valid_i),
    .res_data_i   (res_data_i),
    .res_ready_o  (res_ready_o),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_be_o     (mem_be_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i)
  );

  vrf_mem_model u_mem (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .mem_req_i    (mem_req_o),
    .mem_we_i     (mem_we_o),
    .mem_addr_i   (mem_addr_o),
    .mem_be_i     (mem_be_o),
    .mem_wdata_i  (mem_wdata_o),
    .mem_gnt_o    (mem_gnt_i),
    .mem_rvalid_o (mem_rvalid_i),
    .mem_rdata_o  (mem_rdata_i)
  );

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic int word_count(input int vl, input int sew);
    int bytes;
    bytes = vl << sew;
    return (bytes + 3) / 4;
  endfunction

  function automatic logic [3:0] tail_lanes(input int vl, input int sew);
    int bytes;
    bytes = vl << sew;
    case (bytes % 4)
      1:       return 4'b0001;
      2:       return 4'b0011;
      3:       return 4'b0111;
      default: return 4'b1111;
    endcase
  endfunction

  // Result merged into the old word, disabled lanes keep their bytes
  function automatic logic [`VRF_WORD_W-1:0] expected_word(
    input logic                   binary,
    input logic [`VRF_WORD_W-1:0] a_word,
    input logic [`VRF_WORD_W-1:0] b_word,
    input logic [`VRF_WORD_W-1:0] old_word,
    input logic [3:0]             lanes
  );
    logic [`VRF_WORD_W-1:0] res;
    logic [`VRF_WORD_W-1:0] merged;
    int                     b;
    res    = binary ? a_word + b_word : b_word ^ 32'hA5A5A5A5;
    merged = old_word;
    for (b = 0; b < 4; b++) begin
      if (lanes[b]) merged[8*b +: 8] = res[8*b +: 8];
    end
    return merged;
  endfunction

  task automatic build_expected(input logic binary, input int vl, input int sew,
                                input logic [`VRF_ADDR_W-1:0] vs1,
                                input logic [`VRF_ADDR_W-1:0] vs2,
                                input logic [`VRF_ADDR_W-1:0] vd);
    int                     words;
    int                     k;
    logic [3:0]             lanes;
    logic [`VRF_ADDR_W-1:0] src1;
    logic [`VRF_ADDR_W-1:0] src2;
    logic [`VRF_ADDR_W-1:0] dst;
    for (k = 0; k < mem_words; k++) begin
      snap[k]    = u_mem.mem[k];
      exp_mem[k] = u_mem.mem[k];
    end
    words = word_count(vl, sew);
    for (k = 0; k < words; k++) begin
      lanes = (k == words - 1) ? tail_lanes(vl, sew) : 4'b1111;
      src1  = vs1 + k[`VRF_ADDR_W-1:0];
      src2  = vs2 + k[`VRF_ADDR_W-1:0];
      dst   = vd + k[`VRF_ADDR_W-1:0];
      exp_mem[dst] = expected_word(binary, snap[src1], snap[src2], snap[dst], lanes);
    end
  endtask

  task automatic compare_memory(input string what);
    int i;
    for (i = 0; i < mem_words; i++) begin
      check_cnt++;
      if (u_mem.mem[i] !== exp_mem[i]) begin
        err_cnt++;
        $display("** Error at %0t: %s, word %0d is %h, expected %h",
                 $time, what, i, u_mem.mem[i], exp_mem[i]);
      end
    end
  endtask

  //////////////////////////////
  // Execution unit
  //////////////////////////////

  initial begin
    logic [`VRF_WORD_W-1:0] res_q[$];
    logic                   opnd_fire;
    logic                   res_fire;
    logic [`VRF_WORD_W-1:0] a_s;
    logic [`VRF_WORD_W-1:0] b_s;
    opnd_ready_i = 1'b0;
    res_valid_i  = 1'b0;
    res_data_i   = '0;
    opnd_fire    = 1'b0;
    res_fire     = 1'b0;
    a_s          = '0;
    b_s          = '0;
    forever begin
      @(negedge clk_i);
      // Handshakes of the rising edge just passed
      if (opnd_fire) res_q.push_back(cur_binary ? a_s + b_s : b_s ^ 32'hA5A5A5A5);
      if (res_fire) void'(res_q.pop_front());
      opnd_ready_i = rst_ni && ($urandom_range(1) == 1);
      res_valid_i  = (res_q.size() != 0) && ($urandom_range(4) != 0);
      res_data_i   = (res_q.size() != 0) ? res_q[0] : '0;
      #1;
      opnd_fire = opnd_valid_o && opnd_ready_i;
      a_s       = opnd_a_o;
      b_s       = opnd_b_o;
      res_fire  = res_valid_i && res_ready_o;
    end
  end

  // Done pulses, memory activity and ready while busy
  always @(negedge clk_i) begin
    #2;
    if (rst_ni) begin
      if (mem_req_o) req_cnt++;
      if (done_o) begin
        done_cnt++;
        in_op = 1'b0;
      end else if (in_op && op_ready_o) begin
        err_cnt++;
        $display("** Error at %0t: op_ready_o high before done_o", $time);
      end
      if (op_valid_i && op_ready_o) in_op = 1'b1;
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic run_op(input string what, input logic binary, input int vl, input sew_e sew,
                        input logic [`VRF_ADDR_W-1:0] vs1,
                        input logic [`VRF_ADDR_W-1:0] vs2,
                        input logic [`VRF_ADDR_W-1:0] vd);
    int done_before;
    int req_before;
    int wait_cnt;
    if (timed_out) return;
    @(negedge clk_i);
    build_expected(binary, vl, int'(sew), vs1, vs2, vd);
    cur_binary  = binary;
    done_before = done_cnt;
    req_before  = req_cnt;
    op_valid_i  = 1'b1;
    op_binary_i = binary;
    vl_i        = vl[`VRF_VL_W-1:0];
    sew_i       = sew;
    vs1_addr_i  = vs1;
    vs2_addr_i  = vs2;
    vd_addr_i   = vd;
    wait_cnt    = 0;
    while (!op_ready_o && wait_cnt < 100) begin
      @(negedge clk_i);
      wait_cnt++;
    end
    if (!op_ready_o) begin
      err_cnt++;
      timed_out = 1'b1;
      $display("Timeout: operation '%s' was never accepted", what);
      return;
    end
    @(negedge clk_i);
    op_valid_i = 1'b0;
    wait_cnt   = 0;
    while (!done_o && wait_cnt < 5000) begin
      @(negedge clk_i);
      wait_cnt++;
    end
    if (!done_o) begin
      err_cnt++;
      timed_out = 1'b1;
      $display("Timeout: operation '%s' never raised done_o", what);
      return;
    end
    repeat (4) @(negedge clk_i);
    check_cnt++;
    if (done_cnt != done_before + 1) begin
      err_cnt++;
      $display("** Error at %0t: %s, %0d done pulses", $time, what, done_cnt - done_before);
    end
    if (vl == 0) begin
      check_cnt++;
      if (req_cnt != req_before) begin
        err_cnt++;
        $display("** Error at %0t: %s, memory requested with vl 0", $time, what);
      end
    end
    compare_memory(what);
  endtask

  task automatic check_idle_outputs();
    check_cnt++;
    if (mem_req_o || opnd_valid_o || res_ready_o || done_o || !op_ready_o) begin
      err_cnt++;
      $display("** Error at %0t: outputs after reset not idle", $time);
    end
  endtask

  task automatic end_run();
    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  initial begin
    int                     i;
    int                     n;
    int                     r_vl;
    logic                   r_bin;
    sew_e                   r_sew;
    logic [`VRF_ADDR_W-1:0] r_vs1;
    logic [`VRF_ADDR_W-1:0] r_vs2;
    logic [`VRF_ADDR_W-1:0] r_vd;
    void'($urandom(33166));
    rst_ni      = 1'b0;
    op_valid_i  = 1'b0;
    op_binary_i = 1'b0;
    vl_i        = '0;
    sew_i       = SEW_8;
    vs1_addr_i  = '0;
    vs2_addr_i  = '0;
    vd_addr_i   = '0;
    for (i = 0; i < mem_words; i++) begin
      u_mem.mem[i] = $urandom;
    end
    $display("Operand queue depth %0d", `VRF_QUEUE_DEPTH);
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_idle_outputs();

    run_op("unary word vl 8", 1'b0, 8, SEW_32, 10'h000, 10'h040, 10'h100);
    run_op("binary byte vl 64", 1'b1, 64, SEW_8, 10'h010, 10'h050, 10'h120);
    // Partial last word
    run_op("tail vl 13", 1'b1, 13, SEW_8, 10'h070, 10'h080, 10'h140);
    run_op("tail vl 14", 1'b0, 14, SEW_8, 10'h070, 10'h080, 10'h150);
    run_op("tail vl 15", 1'b1, 15, SEW_8, 10'h070, 10'h080, 10'h160);
    run_op("empty vector", 1'b1, 0, SEW_32, 10'h000, 10'h040, 10'h180);

    // Source and destination windows never overlap
    for (n = 0; n < 20; n++) begin
      r_bin = 1'($urandom_range(1));
      r_sew = sew_e'(2'($urandom_range(2)));
      r_vl  = int'($urandom_range(40));
      r_vs1 = 10'h200 + 10'($urandom_range(63));
      r_vs2 = 10'h280 + 10'($urandom_range(63));
      r_vd  = 10'h300 + 10'($urandom_range(63));
      run_op("random operation", r_bin, r_vl, r_sew, r_vs1, r_vs2, r_vd);
    end
    end_run();
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+common
common/vrf_pkg.sv
src/vrf_op_ctrl.sv
src/vrf_operand_fetch.sv
src/vrf_result_write.sv
src/vrf_mem_arbiter.sv
src/vrf_seq_top.sv
sim/tb_vrf_mem.sv
sim/tb_vrf_seq.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module tb_vrf_seq -o tb_vrf_seq \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/tb_vrf_seq | tee /dev/stderr | grep "Done: no errors" > /dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
